/* src/tmu_wb_pkg.sv */
package tmu_wb_pkg;

	// FML and framebuffer widths.
	localparam int fml_depth = 26;
	localparam int dadr_w = fml_depth - 1; // 16-bit word address.
	localparam int burst_adr_w = fml_depth - 5; // 32-byte burst address.
	localparam int color_w = 16; // RGB565.
	localparam int bright_w = 6;

	// csr map.
	localparam logic [3:0] csr_sel = 4'd0;
	localparam logic [9:0] csr_ctrl = 10'd0;
	localparam logic [9:0] csr_brightness = 10'd3;
	localparam logic [9:0] csr_chroma_key = 10'd4;

	// one finished pixel from the rasterizer.
	typedef struct packed {
		logic [dadr_w-1:0] dadr;
		logic [color_w-1:0] color;
	} pixel_t;

	// a burst of 16 pixels with slot 0 in the top bits.
	typedef struct packed {
		logic [burst_adr_w-1:0] burst_adr;
		logic [15:0] sel;
		logic [255:0] data;
	} burst_t;

	typedef enum logic [1:0] {
		job_idle,
		job_wait_process,
		job_flush,
		job_wait_flush
	} job_state_t;

endpackage

/* src/tmu_ctlif.sv */
`timescale 1ns/10ps

module tmu_ctlif (
	input logic sys_clk,
	input logic sys_rst,

	input logic [13:0] csr_a_i,
	input logic csr_we_i,
	input logic [31:0] csr_di_i,
	output logic [31:0] csr_do_o,

	input logic job_busy_i,
	output logic irq_o,
	output logic frame_end_o,

	output logic [tmu_wb_pkg::bright_w-1:0] brightness_o,
	output logic chroma_key_en_o,
	output logic [tmu_wb_pkg::color_w-1:0] chroma_key_o
);

	import tmu_wb_pkg::*;

	logic csr_selected;
	logic job_busy_q;
	logic busy_bit;

	assign csr_selected = csr_a_i[13:10] == csr_sel;

	// frame end is pending until the job fsm picks it up.
	assign busy_bit = job_busy_i | frame_end_o;

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			csr_do_o <= 32'd0;
			irq_o <= 1'b0;
			frame_end_o <= 1'b0;
			job_busy_q <= 1'b0;
			brightness_o <= 6'd63; // full brightness.
			chroma_key_en_o <= 1'b0;
			chroma_key_o <= '0;
		end else begin
			job_busy_q <= job_busy_i;
			irq_o <= job_busy_q & ~job_busy_i; // falling edge of busy.
			frame_end_o <= 1'b0;
			csr_do_o <= 32'd0;
			if (csr_selected) begin
				if (csr_we_i) begin
					case (csr_a_i[9:0])
						csr_ctrl: begin
							frame_end_o <= csr_di_i[0] & ~job_busy_i;
							chroma_key_en_o <= csr_di_i[1];
						end
						csr_brightness: brightness_o <= csr_di_i[bright_w-1:0];
						csr_chroma_key: chroma_key_o <= csr_di_i[color_w-1:0];
						default: ;
					endcase
				end
				case (csr_a_i[9:0])
					csr_ctrl: csr_do_o <= {30'd0, chroma_key_en_o, busy_bit};
					csr_brightness: csr_do_o <= {26'd0, brightness_o};
					csr_chroma_key: csr_do_o <= {16'd0, chroma_key_o};
					default: csr_do_o <= 32'd0;
				endcase
			end
		end
	end

endmodule

/* src/tmu_decay.sv */
`timescale 1ns/10ps

module tmu_decay (
	input logic sys_clk,
	input logic sys_rst,
	output logic busy_o,

	input logic [tmu_wb_pkg::bright_w-1:0] brightness_i,
	input logic chroma_key_en_i,
	input logic [tmu_wb_pkg::color_w-1:0] chroma_key_i,

	input logic pipe_stb_i,
	output logic pipe_ack_o,
	input tmu_wb_pkg::pixel_t pixel_i,

	output logic pipe_stb_o,
	input logic pipe_ack_i,
	output tmu_wb_pkg::pixel_t pixel_o
);

	import tmu_wb_pkg::*;

	logic [6:0] scale; // brightness plus one, 1 to 64.
	logic [11:0] r_mul;
	logic [12:0] g_mul;
	logic [11:0] b_mul;
	logic drop;
	logic accept;

	assign scale = {1'b0, brightness_i} + 7'd1;
	assign r_mul = pixel_i.color[15:11] * scale;
	assign g_mul = pixel_i.color[10:5] * scale;
	assign b_mul = pixel_i.color[4:0] * scale;

	assign drop = chroma_key_en_i & (pixel_i.color == chroma_key_i);
	assign pipe_ack_o = ~pipe_stb_o | pipe_ack_i;
	assign accept = pipe_stb_i & pipe_ack_o;
	assign busy_o = pipe_stb_o;

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			pipe_stb_o <= 1'b0;
		end else begin
			if (pipe_ack_i)
				pipe_stb_o <= 1'b0;
			if (accept)
				pipe_stb_o <= ~drop; // keyed pixels are swallowed here.
		end
	end

	always_ff @(posedge sys_clk) begin
		if (accept) begin
			pixel_o.dadr <= pixel_i.dadr;
			pixel_o.color <= {r_mul[10:6], g_mul[11:6], b_mul[10:6]}; // shift by 6.
		end
	end

endmodule

/* src/tmu_burst.sv */
`timescale 1ns/10ps

module tmu_burst (
	input logic sys_clk,
	input logic sys_rst,

	input logic flush_i,
	output logic busy_o,

	input logic pipe_stb_i,
	output logic pipe_ack_o,
	input tmu_wb_pkg::pixel_t pixel_i,

	output logic pipe_stb_o,
	input logic pipe_ack_i,
	output tmu_wb_pkg::burst_t burst_o
);

	import tmu_wb_pkg::*;

	// the open burst doubles as the output register.
	logic [burst_adr_w-1:0] burst_adr_q;
	logic [15:0] sel_q;
	logic [255:0] data_q;

	logic [burst_adr_w-1:0] pixel_burst_adr;
	logic [3:0] slot;
	logic [15:0] slot_bit;
	logic sel_nonempty;
	logic adr_mismatch;
	logic fresh;
	logic accept;
	logic emit;

	assign pixel_burst_adr = pixel_i.dadr[dadr_w-1:4];
	assign slot = pixel_i.dadr[3:0];
	assign slot_bit = 16'h8000 >> slot; // slot 0 is the msb.

	assign sel_nonempty = |sel_q;
	assign adr_mismatch = pixel_burst_adr != burst_adr_q;

	// a pixel starts a new burst when the held one is empty or leaving now.
	assign fresh = pipe_stb_o | ~sel_nonempty;

	always_comb begin
		if (pipe_stb_o)
			pipe_ack_o = pipe_ack_i;
		else
			pipe_ack_o = ~(sel_nonempty & (adr_mismatch | flush_i));
	end

	assign accept = pipe_stb_i & pipe_ack_o;
	assign emit = ~pipe_stb_o & sel_nonempty & ((pipe_stb_i & adr_mismatch) | flush_i);

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			pipe_stb_o <= 1'b0;
			sel_q <= 16'd0;
		end else begin
			if (pipe_ack_i)
				pipe_stb_o <= 1'b0;
			if (emit)
				pipe_stb_o <= 1'b1;
			if (accept)
				sel_q <= (fresh ? 16'd0 : sel_q) | slot_bit;
			else if (pipe_stb_o & pipe_ack_i)
				sel_q <= 16'd0; // burst handed over.
		end
	end

	always_ff @(posedge sys_clk) begin
		if (accept) begin
			if (fresh)
				burst_adr_q <= pixel_burst_adr;
			data_q[16*(15-slot) +: 16] <= pixel_i.color; // last write wins.
		end
	end

	assign burst_o.burst_adr = burst_adr_q;
	assign burst_o.sel = sel_q;
	assign burst_o.data = data_q;

	assign busy_o = pipe_stb_o;

endmodule

/* src/tmu_pixout.sv */
`timescale 1ns/10ps

module tmu_pixout (
	input logic sys_clk,
	input logic sys_rst,
	output logic busy_o,

	input logic pipe_stb_i,
	output logic pipe_ack_o,
	input tmu_wb_pkg::burst_t burst_i,

	output logic [tmu_wb_pkg::fml_depth-1:0] fmlw_adr_o,
	output logic fmlw_stb_o,
	input logic fmlw_ack_i,
	output logic [7:0] fmlw_sel_o,
	output logic [63:0] fmlw_do_o
);

	import tmu_wb_pkg::*;

	burst_t burst_q;
	logic beat_active;
	logic [1:0] beat_cnt;
	logic [3:0] beat_sel;
	logic accept;

	// next burst may come in during the last beat.
	assign pipe_ack_o = ~fmlw_stb_o & (~beat_active | (beat_cnt == 2'd3));
	assign accept = pipe_stb_i & pipe_ack_o;
	assign busy_o = fmlw_stb_o | beat_active;

	always_ff @(posedge sys_clk) begin
		if (sys_rst) begin
			fmlw_stb_o <= 1'b0;
			beat_active <= 1'b0;
			beat_cnt <= 2'd0;
		end else begin
			if (beat_active) begin
				beat_cnt <= beat_cnt + 2'd1;
				if (beat_cnt == 2'd3)
					beat_active <= 1'b0;
			end
			if (fmlw_stb_o & fmlw_ack_i) begin
				fmlw_stb_o <= 1'b0;
				beat_active <= 1'b1; // beat 0 on the next cycle.
				beat_cnt <= 2'd0;
			end
			if (accept)
				fmlw_stb_o <= 1'b1;
		end
	end

	always_ff @(posedge sys_clk) begin
		if (accept)
			burst_q <= burst_i;
	end

	assign fmlw_adr_o = {burst_q.burst_adr, 5'd0};

	// beat k carries slots 4k to 4k+3, msb first.
	assign fmlw_do_o = burst_q.data[64*(3-beat_cnt) +: 64];
	assign beat_sel = burst_q.sel[4*(3-beat_cnt) +: 4];
	assign fmlw_sel_o = {
		{2{beat_sel[3]}},
		{2{beat_sel[2]}},
		{2{beat_sel[1]}},
		{2{beat_sel[0]}}
	};

endmodule

/* src/tmu_writeback.sv */
`timescale 1ns/10ps

module tmu_writeback (
	input logic sys_clk,
	input logic sys_rst,

	input logic [13:0] csr_a_i,
	input logic csr_we_i,
	input logic [31:0] csr_di_i,
	output logic [31:0] csr_do_o,
	output logic irq_o,

	input logic pixel_stb_i,
	output logic pixel_ack_o,
	input tmu_wb_pkg::pixel_t pixel_i,

	output logic [tmu_wb_pkg::fml_depth-1:0] fmlw_adr_o,
	output logic fmlw_stb_o,
	input logic fmlw_ack_i,
	output logic [7:0] fmlw_sel_o,
	output logic [63:0] fmlw_do_o
);

	import tmu_wb_pkg::*;

	logic frame_end;
	logic job_busy;
	logic flush;
	logic [bright_w-1:0] brightness;
	logic chroma_key_en;
	logic [color_w-1:0] chroma_key;

	logic decay_busy, burst_busy, pixout_busy;
	logic decay_stb, decay_ack;
	pixel_t decay_pixel;
	logic burst_stb, burst_ack;
	burst_t burst_data;
	logic pipeline_busy;

	job_state_t state, next_state;

	tmu_ctlif ctlif (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.csr_a_i(csr_a_i),
		.csr_we_i(csr_we_i),
		.csr_di_i(csr_di_i),
		.csr_do_o(csr_do_o),
		.job_busy_i(job_busy),
		.irq_o(irq_o),
		.frame_end_o(frame_end),
		.brightness_o(brightness),
		.chroma_key_en_o(chroma_key_en),
		.chroma_key_o(chroma_key)
	);

	// decay and chroma key.
	tmu_decay decay (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.busy_o(decay_busy),
		.brightness_i(brightness),
		.chroma_key_en_i(chroma_key_en),
		.chroma_key_i(chroma_key),
		.pipe_stb_i(pixel_stb_i),
		.pipe_ack_o(pixel_ack_o),
		.pixel_i(pixel_i),
		.pipe_stb_o(decay_stb),
		.pipe_ack_i(decay_ack),
		.pixel_o(decay_pixel)
	);

	tmu_burst burst (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.flush_i(flush),
		.busy_o(burst_busy),
		.pipe_stb_i(decay_stb),
		.pipe_ack_o(decay_ack),
		.pixel_i(decay_pixel),
		.pipe_stb_o(burst_stb),
		.pipe_ack_i(burst_ack),
		.burst_o(burst_data)
	);

	tmu_pixout pixout (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.busy_o(pixout_busy),
		.pipe_stb_i(burst_stb),
		.pipe_ack_o(burst_ack),
		.burst_i(burst_data),
		.fmlw_adr_o(fmlw_adr_o),
		.fmlw_stb_o(fmlw_stb_o),
		.fmlw_ack_i(fmlw_ack_i),
		.fmlw_sel_o(fmlw_sel_o),
		.fmlw_do_o(fmlw_do_o)
	);

	assign pipeline_busy = decay_busy | burst_busy | pixout_busy;

	// drain, flush the partial burst, then wait for it to leave.
	always_ff @(posedge sys_clk) begin
		if (sys_rst)
			state <= job_idle;
		else
			state <= next_state;
	end

	always_comb begin
		next_state = state;
		case (state)
			job_idle: if (frame_end) next_state = job_wait_process;
			job_wait_process: if (~pipeline_busy) next_state = job_flush;
			job_flush: next_state = job_wait_flush;
			job_wait_flush: if (~pipeline_busy) next_state = job_idle;
			default: next_state = job_idle;
		endcase
	end

	assign job_busy = state != job_idle;
	assign flush = state == job_flush; // one cycle.

endmodule

/* tests/tb_tmu_writeback.sv */
`timescale 1ns/10ps

module tb_tmu_writeback;

	import tmu_wb_pkg::*;

	localparam int num_frames = 3;
	localparam int num_pixels = 400;
	localparam int timeout_cycles = 20 * num_pixels + 1000;
	localparam logic [dadr_w-1:0] window_base = 25'h0010000; // 64-word window.

	logic sys_clk;
	logic sys_rst;
	logic [13:0] csr_a_i;
	logic csr_we_i;
	logic [31:0] csr_di_i;
	logic [31:0] csr_do_o;
	logic irq_o;
	logic pixel_stb_i;
	logic pixel_ack_o;
	pixel_t pixel_i;
	logic [fml_depth-1:0] fmlw_adr_o;
	logic fmlw_stb_o;
	logic fmlw_ack_i;
	logic [7:0] fmlw_sel_o;
	logic [63:0] fmlw_do_o;

	integer seed = 99;
	integer ack_seed = 99;
	int value_errors = 0;
	int other_errors = 0;
	int cycle_count = 0;
	int irq_count = 0;
	int fml_writes = 0;
	int pixels_sent = 0;
	int ack_wait = 0;

	// model of the framebuffer.
	logic [5:0] brightness;
	logic [15:0] chroma_key;
	logic key_en;
	logic [15:0] expected_mem [logic [dadr_w-1:0]];
	logic [15:0] observed_mem [logic [dadr_w-1:0]];
	bit sent_set [logic [dadr_w-1:0]];

	logic [dadr_w-1:0] beat_word;
	logic [dadr_w-1:0] sel_word;
	int beats_left = 0;
	logic stb_prev = 1'b0;
	logic [fml_depth-1:0] adr_prev;

	tmu_writeback UUT (
		.sys_clk(sys_clk),
		.sys_rst(sys_rst),
		.csr_a_i(csr_a_i),
		.csr_we_i(csr_we_i),
		.csr_di_i(csr_di_i),
		.csr_do_o(csr_do_o),
		.irq_o(irq_o),
		.pixel_stb_i(pixel_stb_i),
		.pixel_ack_o(pixel_ack_o),
		.pixel_i(pixel_i),
		.fmlw_adr_o(fmlw_adr_o),
		.fmlw_stb_o(fmlw_stb_o),
		.fmlw_ack_i(fmlw_ack_i),
		.fmlw_sel_o(fmlw_sel_o),
		.fmlw_do_o(fmlw_do_o)
	);

	initial begin
		sys_clk = 1'b0;
		forever #2 sys_clk = ~sys_clk;
	end

	initial begin
		while (cycle_count < timeout_cycles) begin
			@(posedge sys_clk);
			cycle_count++;
		end
		$display("run timed out after %0d cycles", cycle_count);
		$display("Checks failed");
		$finish;
	end

	// memory side acks after 0 to 7 cycles.
	always @(posedge sys_clk) begin
		#1;
		if (fmlw_stb_o && !fmlw_ack_i) begin
			if (ack_wait == 0) begin
				fmlw_ack_i = 1'b1;
				ack_wait = $random(ack_seed) & 7;
			end else
				ack_wait = ack_wait - 1;
		end else
			fmlw_ack_i = 1'b0;
	end

	// rebuilds memory from the fml beats.
	always @(negedge sys_clk) begin
		if (beats_left > 0) begin
			for (int j = 0; j < 4; j++) begin
				assert (fmlw_sel_o[7-2*j] == fmlw_sel_o[6-2*j]) else begin
					value_errors++;
					$display("CHECK FAILED fmlw_sel_o: 0x%h has split pixel bits", fmlw_sel_o);
				end
				if (fmlw_sel_o[7-2*j]) begin
					sel_word = beat_word + j;
					assert (sent_set.exists(sel_word)) else begin
						other_errors++;
						$display("write selects word 0x%h that was never sent", sel_word);
					end
					observed_mem[sel_word] = fmlw_do_o[63-16*j -: 16];
				end
			end
			beat_word = beat_word + 4;
			beats_left--;
		end
		if (fmlw_stb_o) begin
			if (stb_prev) begin
				assert (fmlw_adr_o == adr_prev) else begin
					value_errors++;
					$display("CHECK FAILED fmlw_adr_o: got 0x%h, held 0x%h", fmlw_adr_o, adr_prev);
				end
			end
			if (fmlw_ack_i) begin
				beat_word = fmlw_adr_o[fml_depth-1:1];
				beats_left = 4;
				fml_writes++;
			end
		end
		stb_prev = fmlw_stb_o;
		adr_prev = fmlw_adr_o;
		if (irq_o)
			irq_count++; // counts high cycles.
	end

	function automatic logic [15:0] decay_color(input logic [15:0] c, input logic [5:0] b);
		int s;
		int r;
		int g;
		int bl;
		s = b + 1;
		r = (c[15:11] * s) >> 6;
		g = (c[10:5] * s) >> 6;
		bl = (c[4:0] * s) >> 6;
		return {r[4:0], g[5:0], bl[4:0]};
	endfunction

	task automatic write_csr(input logic [13:0] adr, input logic [31:0] data);
		csr_a_i = adr;
		csr_di_i = data;
		csr_we_i = 1'b1;
		@(posedge sys_clk);
		#1;
		csr_we_i = 1'b0;
	endtask

	task automatic expect_csr(input logic [13:0] adr, input logic [31:0] exp, input string name);
		csr_a_i = adr;
		csr_we_i = 1'b0;
		@(posedge sys_clk);
		#1;
		assert (csr_do_o == exp) else begin
			value_errors++;
			$display("CHECK FAILED csr_do_o (%s): got 0x%h, expected 0x%h", name, csr_do_o, exp);
		end
	endtask

	task automatic send_pixel(input pixel_t px);
		int gap;
		gap = $random(seed) & 3;
		repeat (gap) begin
			@(posedge sys_clk);
			#1;
		end
		pixel_i = px;
		pixel_stb_i = 1'b1;
		@(negedge sys_clk);
		while (!pixel_ack_o)
			@(negedge sys_clk);
		sent_set[px.dadr] = 1'b1;
		if (!(key_en && px.color == chroma_key))
			expected_mem[px.dadr] = decay_color(px.color, brightness); // last write wins.
		pixels_sent++;
		@(posedge sys_clk);
		#1;
		pixel_stb_i = 1'b0;
	endtask

	task automatic compare_memory();
		assert (observed_mem.num() == expected_mem.num()) else begin
			value_errors++;
			$display("CHECK FAILED memory size: got 0x%h, expected 0x%h",
				observed_mem.num(), expected_mem.num());
		end
		foreach (expected_mem[a]) begin
			assert (observed_mem.exists(a)) else begin
				other_errors++;
				$display("word 0x%h was never written to memory", a);
			end
			if (observed_mem.exists(a)) begin
				assert (observed_mem[a] == expected_mem[a]) else begin
					value_errors++;
					$display("CHECK FAILED mem[0x%h]: got 0x%h, expected 0x%h",
						a, observed_mem[a], expected_mem[a]);
				end
			end
		end
	endtask

	initial begin
		pixel_t px;
		int count;
		sys_rst = 1'b1;
		csr_a_i = '0;
		csr_we_i = 1'b0;
		csr_di_i = '0;
		pixel_stb_i = 1'b0;
		pixel_i = '0;
		fmlw_ack_i = 1'b0;
		repeat (4) @(posedge sys_clk);
		#1;
		sys_rst = 1'b0;

		expect_csr({csr_sel, csr_brightness}, 32'd63, "brightness");
		expect_csr({csr_sel, csr_chroma_key}, 32'd0, "chroma_key");
		expect_csr({csr_sel, csr_ctrl}, 32'd0, "ctrl");
		expect_csr({4'd1, csr_brightness}, 32'd0, "unselected");

		for (int f = 0; f < num_frames; f++) begin
			brightness = $random(seed) & 63;
			chroma_key = $random(seed);
			key_en = (f == 1); // middle frame drops keyed pixels.
			write_csr({csr_sel, csr_brightness}, {26'd0, brightness});
			write_csr({csr_sel, csr_chroma_key}, {16'd0, chroma_key});
			write_csr({csr_sel, csr_ctrl}, {30'd0, key_en, 1'b0});
			expect_csr({csr_sel, csr_brightness}, {26'd0, brightness}, "brightness");
			expect_csr({csr_sel, csr_chroma_key}, {16'd0, chroma_key}, "chroma_key");
			expect_csr({csr_sel, csr_ctrl}, {30'd0, key_en, 1'b0}, "ctrl");

			count = (f == 0) ? num_pixels - 2 * (num_pixels / 3) : num_pixels / 3;
			for (int i = 0; i < count; i++) begin
				px.dadr = window_base + ($random(seed) & 63);
				if (($random(seed) & 3) == 0)
					px.color = chroma_key;
				else
					px.color = $random(seed);
				send_pixel(px);
			end

			// end of frame, then drain and flush.
			write_csr({csr_sel, csr_ctrl}, {30'd0, key_en, 1'b1});
			expect_csr({csr_sel, csr_ctrl}, {30'd0, key_en, 1'b1}, "ctrl busy");
			@(negedge sys_clk);
			while (!irq_o)
				@(negedge sys_clk);
			@(posedge sys_clk);
			#1;
			compare_memory(); // the flushed burst is already in memory here.
			repeat (4) @(posedge sys_clk);
			#1;
			assert (irq_count == f + 1) else begin
				other_errors++;
				$display("frame %0d gave %0d irq cycles in total", f, irq_count);
			end
			expect_csr({csr_sel, csr_ctrl}, {30'd0, key_en, 1'b0}, "ctrl idle");
			assert (fml_writes <= pixels_sent) else begin
				other_errors++;
				$display("%0d fml writes for only %0d pixels", fml_writes, pixels_sent);
			end
		end

		$display("value errors: %0d, other errors: %0d", value_errors, other_errors);
		if (value_errors + other_errors == 0)
			$display("All checks passed");
		else
			$display("Checks failed");
		$finish;
	end

endmodule

/* tmu_writeback.f */
src/tmu_wb_pkg.sv
src/tmu_ctlif.sv
src/tmu_decay.sv
src/tmu_burst.sv
src/tmu_pixout.sv
src/tmu_writeback.sv
tests/tb_tmu_writeback.sv
